// ==== src/dbg_mam_params.svh ====
/*
 * Global sizes of the debug memory access subsystem
 * - bus widths, SRAM depth and wait states, MAM read length limit
 */

`ifndef DBG_MAM_PARAMS_SVH
`define DBG_MAM_PARAMS_SVH

// Address and data width
`define DBG_PLEN 32
`define DBG_XLEN 32

// SRAM depth in 32-bit words, byte addresses from 1024 up are out of range
`define DBG_MEM_WORDS 256

// Wait cycles per SRAM data phase
`define DBG_MEM_WAIT 1

// Longest MAM read in words
`define DBG_MAM_MAX_LEN 8

`endif

// ==== src/dbg_mam_pkg.sv ====
/*
 * Shared types for the debug memory access subsystem
 * - AHB3 transfer type encoding
 * - FSM state encodings of arbiter, MAM engine and SRAM slave
 */

package dbg_mam_pkg;

  // AHB3 HTRANS encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Bus owner as seen by the arbiter
  typedef enum logic [1:0] {
    ARB_IDLE = 2'd0,
    ARB_MAM  = 2'd1,
    ARB_CPU  = 2'd2
  } arb_state_t;

  // MAM engine sequencing, one word per ADDR/DATA round
  typedef enum logic [2:0] {
    MAM_IDLE = 3'd0,
    MAM_LOCK = 3'd1,
    MAM_ADDR = 3'd2,
    MAM_DATA = 3'd3,
    MAM_DONE = 3'd4
  } mam_state_t;

  // SRAM data phase tracking
  typedef enum logic [1:0] {
    SR_IDLE = 2'd0,
    SR_WAIT = 2'd1,
    SR_ERR2 = 2'd2
  } sram_state_t;

endpackage

// ==== src/dbg_mam_access_engine.sv ====
/*
 * Debug memory access engine
 * - takes one-cycle command strobes (write one word, read 1..8 words)
 * - issues locked AHB3 single transfers, one word at a time
 * - returns read words with a valid pulse, ends with done and error status
 */

`timescale 1ns/1ps
`include "dbg_mam_params.svh"

module dbg_mam_access_engine (
  input  logic                 ahb3_in_clk_i,
  input  logic                 arst_n_i,

  // Debug command side
  input  logic                 mam_req_i,
  input  logic                 mam_we_i,
  input  logic [`DBG_PLEN-1:0] mam_addr_i,
  input  logic [3:0]           mam_len_i,
  input  logic [`DBG_XLEN-1:0] mam_wdata_i,
  output logic [`DBG_XLEN-1:0] mam_rdata_o,
  output logic                 mam_rvalid_o,
  output logic                 mam_done_o,
  output logic                 mam_err_o,
  output logic                 mam_busy_o,

  // AHB3 master side
  output logic                 ahb3_mam_hsel_o,
  output logic [`DBG_PLEN-1:0] ahb3_mam_haddr_o,
  output logic [`DBG_XLEN-1:0] ahb3_mam_hwdata_o,
  output logic                 ahb3_mam_hwrite_o,
  output logic [2:0]           ahb3_mam_hsize_o,
  output logic [2:0]           ahb3_mam_hburst_o,
  output logic [1:0]           ahb3_mam_htrans_o,
  output logic                 ahb3_mam_hmastlock_o,
  input  logic [`DBG_XLEN-1:0] ahb3_mam_hrdata_i,
  input  logic                 ahb3_mam_hready_i,
  input  logic                 ahb3_mam_hresp_i
);

  dbg_mam_pkg::mam_state_t state_q;
  logic [`DBG_PLEN-1:0]    addr_q;
  logic [`DBG_XLEN-1:0]    wdata_q;
  logic                    we_q;
  logic [3:0]              cnt_q;
  logic                    err_q;
  logic [3:0]              len_eff;
  logic                    start;
  logic                    beat_done;

  assign start     = mam_req_i && (state_q == dbg_mam_pkg::MAM_IDLE);
  assign beat_done = (state_q == dbg_mam_pkg::MAM_DATA) && ahb3_mam_hready_i;

  // Writes are single word, zero means one, long reads are clipped
  always_comb begin
    if (mam_we_i || (mam_len_i == 4'd0)) begin
      len_eff = 4'd1;
    end else if (mam_len_i > 4'(`DBG_MAM_MAX_LEN)) begin
      len_eff = 4'(`DBG_MAM_MAX_LEN);
    end else begin
      len_eff = mam_len_i;
    end
  end

  //////////////////////////////
  // Control FSM
  //////////////////////////////
  always_ff @(posedge ahb3_in_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= dbg_mam_pkg::MAM_IDLE;
      cnt_q        <= 4'd0;
      err_q        <= 1'b0;
      mam_rvalid_o <= 1'b0;
    end else begin
      mam_rvalid_o <= 1'b0;
      case (state_q)
        dbg_mam_pkg::MAM_IDLE: begin
          if (start) begin
            state_q <= dbg_mam_pkg::MAM_LOCK;
            cnt_q   <= len_eff;
            err_q   <= 1'b0;
          end
        end
        // One cycle of lock before the first address phase
        dbg_mam_pkg::MAM_LOCK: state_q <= dbg_mam_pkg::MAM_ADDR;
        dbg_mam_pkg::MAM_ADDR: begin
          if (ahb3_mam_hready_i) begin
            state_q <= dbg_mam_pkg::MAM_DATA;
          end
        end
        dbg_mam_pkg::MAM_DATA: begin
          if (beat_done) begin
            if (ahb3_mam_hresp_i) begin
              // Abort the remaining words
              err_q   <= 1'b1;
              state_q <= dbg_mam_pkg::MAM_DONE;
            end else begin
              mam_rvalid_o <= ~we_q;
              cnt_q        <= cnt_q - 4'd1;
              state_q      <= (cnt_q == 4'd1) ? dbg_mam_pkg::MAM_DONE
                                              : dbg_mam_pkg::MAM_ADDR;
            end
          end
        end
        default: state_q <= dbg_mam_pkg::MAM_IDLE;
      endcase
    end
  end

  // Command payload and read data
  always_ff @(posedge ahb3_in_clk_i) begin
    if (start) begin
      addr_q  <= {mam_addr_i[`DBG_PLEN-1:2], 2'b00};
      wdata_q <= mam_wdata_i;
      we_q    <= mam_we_i;
    end else if (beat_done && !ahb3_mam_hresp_i) begin
      addr_q <= addr_q + `DBG_PLEN'(4);
    end
    if (beat_done && !we_q) begin
      mam_rdata_o <= ahb3_mam_hrdata_i;
    end
  end

  //////////////////////////////
  // Bus and status outputs
  //////////////////////////////
  assign ahb3_mam_hmastlock_o = (state_q == dbg_mam_pkg::MAM_LOCK) ||
                                (state_q == dbg_mam_pkg::MAM_ADDR) ||
                                (state_q == dbg_mam_pkg::MAM_DATA);
  assign ahb3_mam_hsel_o      = ahb3_mam_hmastlock_o;
  assign ahb3_mam_htrans_o    = (state_q == dbg_mam_pkg::MAM_ADDR) ? dbg_mam_pkg::NONSEQ
                                                                   : dbg_mam_pkg::IDLE;
  assign ahb3_mam_haddr_o     = addr_q;
  assign ahb3_mam_hwdata_o    = wdata_q;
  assign ahb3_mam_hwrite_o    = (state_q == dbg_mam_pkg::MAM_ADDR) && we_q;
  // Word size, single transfers
  assign ahb3_mam_hsize_o     = 3'b010;
  assign ahb3_mam_hburst_o    = 3'b000;

  assign mam_done_o = (state_q == dbg_mam_pkg::MAM_DONE);
  assign mam_err_o  = mam_done_o && err_q;
  assign mam_busy_o = (state_q != dbg_mam_pkg::MAM_IDLE);

endmodule

// ==== src/dbg_mam_ahb3_arbiter.sv ====
/*
 * AHB3 arbiter between the CPU port and the MAM engine
 * - MAM wins when the bus is idle, CPU keeps the bus while locked
 * - registered select steers requests to the SRAM and responses back
 */

`timescale 1ns/1ps
`include "dbg_mam_params.svh"

module dbg_mam_ahb3_arbiter (
  input  logic                 ahb3_in_clk_i,
  input  logic                 arst_n_i,

  // CPU master, slave direction
  input  logic                 ahb3_in_hsel_i,
  input  logic [`DBG_PLEN-1:0] ahb3_in_haddr_i,
  input  logic [`DBG_XLEN-1:0] ahb3_in_hwdata_i,
  input  logic                 ahb3_in_hwrite_i,
  input  logic [2:0]           ahb3_in_hsize_i,
  input  logic [2:0]           ahb3_in_hburst_i,
  input  logic [1:0]           ahb3_in_htrans_i,
  input  logic                 ahb3_in_hmastlock_i,
  output logic [`DBG_XLEN-1:0] ahb3_in_hrdata_o,
  output logic                 ahb3_in_hready_o,
  output logic                 ahb3_in_hresp_o,

  // MAM master, slave direction
  input  logic                 ahb3_mam_hsel_i,
  input  logic [`DBG_PLEN-1:0] ahb3_mam_haddr_i,
  input  logic [`DBG_XLEN-1:0] ahb3_mam_hwdata_i,
  input  logic                 ahb3_mam_hwrite_i,
  input  logic [2:0]           ahb3_mam_hsize_i,
  input  logic [2:0]           ahb3_mam_hburst_i,
  input  logic [1:0]           ahb3_mam_htrans_i,
  input  logic                 ahb3_mam_hmastlock_i,
  output logic [`DBG_XLEN-1:0] ahb3_mam_hrdata_o,
  output logic                 ahb3_mam_hready_o,
  output logic                 ahb3_mam_hresp_o,

  // Memory, master direction
  output logic                 ahb3_mem_hsel_o,
  output logic [`DBG_PLEN-1:0] ahb3_mem_haddr_o,
  output logic [`DBG_XLEN-1:0] ahb3_mem_hwdata_o,
  output logic                 ahb3_mem_hwrite_o,
  output logic [2:0]           ahb3_mem_hsize_o,
  output logic [2:0]           ahb3_mem_hburst_o,
  output logic [1:0]           ahb3_mem_htrans_o,
  output logic                 ahb3_mem_hmastlock_o,
  input  logic [`DBG_XLEN-1:0] ahb3_mem_hrdata_i,
  input  logic                 ahb3_mem_hready_i,
  input  logic                 ahb3_mem_hresp_i
);

  dbg_mam_pkg::arb_state_t arb_state_q;
  dbg_mam_pkg::arb_state_t arb_state_d;
  logic                    sel_cpu_q;
  logic                    owner_ok;

  //////////////////////////////
  // Ownership FSM
  //////////////////////////////
  always_comb begin
    arb_state_d = dbg_mam_pkg::ARB_IDLE;
    case (arb_state_q)
      dbg_mam_pkg::ARB_IDLE: begin
        if (ahb3_mam_hmastlock_i) begin
          arb_state_d = dbg_mam_pkg::ARB_MAM;
        end else if (ahb3_in_hmastlock_i) begin
          arb_state_d = dbg_mam_pkg::ARB_CPU;
        end
      end
      dbg_mam_pkg::ARB_MAM: begin
        if (ahb3_mam_hmastlock_i) begin
          arb_state_d = dbg_mam_pkg::ARB_MAM;
        end
      end
      dbg_mam_pkg::ARB_CPU: begin
        // CPU finishes its locked sequence, then a waiting MAM goes next
        if (ahb3_in_hmastlock_i) begin
          arb_state_d = dbg_mam_pkg::ARB_CPU;
        end else if (ahb3_mam_hmastlock_i) begin
          arb_state_d = dbg_mam_pkg::ARB_MAM;
        end
      end
      default: arb_state_d = dbg_mam_pkg::ARB_IDLE;
    endcase
  end

  // Select trails the grant by one cycle, holds while idle
  always_ff @(posedge ahb3_in_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      arb_state_q <= dbg_mam_pkg::ARB_IDLE;
      sel_cpu_q   <= 1'b0;
    end else begin
      arb_state_q <= arb_state_d;
      if (arb_state_q == dbg_mam_pkg::ARB_CPU) begin
        sel_cpu_q <= 1'b1;
      end else if (arb_state_q == dbg_mam_pkg::ARB_MAM) begin
        sel_cpu_q <= 1'b0;
      end
    end
  end

  // Select and owner agree, otherwise keep the memory idle
  assign owner_ok = sel_cpu_q ? (arb_state_q == dbg_mam_pkg::ARB_CPU)
                              : (arb_state_q == dbg_mam_pkg::ARB_MAM);

  //////////////////////////////
  // Request and response muxes
  //////////////////////////////
  assign ahb3_mem_hsel_o      = sel_cpu_q ? ahb3_in_hsel_i      : ahb3_mam_hsel_i;
  assign ahb3_mem_haddr_o     = sel_cpu_q ? ahb3_in_haddr_i     : ahb3_mam_haddr_i;
  assign ahb3_mem_hwdata_o    = sel_cpu_q ? ahb3_in_hwdata_i    : ahb3_mam_hwdata_i;
  assign ahb3_mem_hwrite_o    = sel_cpu_q ? ahb3_in_hwrite_i    : ahb3_mam_hwrite_i;
  assign ahb3_mem_hsize_o     = sel_cpu_q ? ahb3_in_hsize_i     : ahb3_mam_hsize_i;
  assign ahb3_mem_hburst_o    = sel_cpu_q ? ahb3_in_hburst_i    : ahb3_mam_hburst_i;
  assign ahb3_mem_hmastlock_o = sel_cpu_q ? ahb3_in_hmastlock_i : ahb3_mam_hmastlock_i;
  assign ahb3_mem_htrans_o    = !owner_ok ? dbg_mam_pkg::IDLE :
                                sel_cpu_q ? ahb3_in_htrans_i  : ahb3_mam_htrans_i;

  // Side without the bus is stalled with hready low
  assign ahb3_in_hrdata_o  = (owner_ok && sel_cpu_q) ? ahb3_mem_hrdata_i : '0;
  assign ahb3_in_hready_o  = owner_ok && sel_cpu_q && ahb3_mem_hready_i;
  assign ahb3_in_hresp_o   = owner_ok && sel_cpu_q && ahb3_mem_hresp_i;
  assign ahb3_mam_hrdata_o = (owner_ok && !sel_cpu_q) ? ahb3_mem_hrdata_i : '0;
  assign ahb3_mam_hready_o = owner_ok && !sel_cpu_q && ahb3_mem_hready_i;
  assign ahb3_mam_hresp_o  = owner_ok && !sel_cpu_q && ahb3_mem_hresp_i;

endmodule

// ==== src/dbg_ahb3_sram.sv ====
/*
 * AHB3 slave word memory
 * - configurable wait states per data phase
 * - two-cycle ERROR response beyond the last word
 */

`timescale 1ns/1ps
`include "dbg_mam_params.svh"

module dbg_ahb3_sram (
  input  logic                 ahb3_in_clk_i,
  input  logic                 arst_n_i,

  input  logic                 ahb3_mem_hsel_i,
  input  logic [`DBG_PLEN-1:0] ahb3_mem_haddr_i,
  input  logic [`DBG_XLEN-1:0] ahb3_mem_hwdata_i,
  input  logic                 ahb3_mem_hwrite_i,
  input  logic [1:0]           ahb3_mem_htrans_i,
  output logic [`DBG_XLEN-1:0] ahb3_mem_hrdata_o,
  output logic                 ahb3_mem_hready_o,
  output logic                 ahb3_mem_hresp_o
);

  localparam int AW = $clog2(`DBG_MEM_WORDS);

  logic [`DBG_XLEN-1:0]     mem [`DBG_MEM_WORDS];
  dbg_mam_pkg::sram_state_t state_q;
  logic [AW-1:0]            idx_q;
  logic                     we_q;
  logic                     bad_q;
  logic [7:0]               wait_q;
  logic                     accept;
  logic                     in_range;
  logic                     last;

  // Word index must fall inside the array
  assign in_range = (ahb3_mem_haddr_i[`DBG_PLEN-1:2] < `DBG_MEM_WORDS);
  assign accept   = ahb3_mem_hready_o && ahb3_mem_hsel_i &&
                    (ahb3_mem_htrans_i == dbg_mam_pkg::NONSEQ);
  // Final cycle of a good data phase
  assign last     = (state_q == dbg_mam_pkg::SR_WAIT) && !bad_q && (wait_q == 8'd0);

  //////////////////////////////
  // Data phase tracking
  //////////////////////////////
  always_ff @(posedge ahb3_in_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= dbg_mam_pkg::SR_IDLE;
      wait_q  <= 8'd0;
      bad_q   <= 1'b0;
    end else if (accept) begin
      state_q <= dbg_mam_pkg::SR_WAIT;
      wait_q  <= 8'(`DBG_MEM_WAIT);
      bad_q   <= !in_range;
    end else if (state_q == dbg_mam_pkg::SR_WAIT) begin
      if (bad_q) begin
        state_q <= dbg_mam_pkg::SR_ERR2;
      end else if (wait_q != 8'd0) begin
        wait_q <= wait_q - 8'd1;
      end else begin
        state_q <= dbg_mam_pkg::SR_IDLE;
      end
    end else begin
      state_q <= dbg_mam_pkg::SR_IDLE;
    end
  end

  // Address phase capture
  always_ff @(posedge ahb3_in_clk_i) begin
    if (accept) begin
      idx_q <= ahb3_mem_haddr_i[AW+1:2];
      we_q  <= ahb3_mem_hwrite_i;
    end
  end

  // Write lands in the last data phase cycle
  always_ff @(posedge ahb3_in_clk_i) begin
    if (last && we_q) begin
      mem[idx_q] <= ahb3_mem_hwdata_i;
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////
  assign ahb3_mem_hready_o = (state_q == dbg_mam_pkg::SR_IDLE) ||
                             (state_q == dbg_mam_pkg::SR_ERR2) || last;
  assign ahb3_mem_hresp_o  = ((state_q == dbg_mam_pkg::SR_WAIT) && bad_q) ||
                             (state_q == dbg_mam_pkg::SR_ERR2);
  assign ahb3_mem_hrdata_o = (last && !we_q) ? mem[idx_q] : '0;

endmodule

// ==== src/dbg_mam_soc_top.sv ====
/*
 * Debug memory access subsystem top
 * - MAM engine and CPU port share one SRAM through the arbiter
 */

`timescale 1ns/1ps
`include "dbg_mam_params.svh"

module dbg_mam_soc_top (
  input  logic                 ahb3_in_clk_i,
  input  logic                 arst_n_i,

  // CPU AHB3 port
  input  logic                 ahb3_in_hsel_i,
  input  logic [`DBG_PLEN-1:0] ahb3_in_haddr_i,
  input  logic [`DBG_XLEN-1:0] ahb3_in_hwdata_i,
  input  logic                 ahb3_in_hwrite_i,
  input  logic [2:0]           ahb3_in_hsize_i,
  input  logic [2:0]           ahb3_in_hburst_i,
  input  logic [1:0]           ahb3_in_htrans_i,
  input  logic                 ahb3_in_hmastlock_i,
  output logic [`DBG_XLEN-1:0] ahb3_in_hrdata_o,
  output logic                 ahb3_in_hready_o,
  output logic                 ahb3_in_hresp_o,

  // Debug command port
  input  logic                 mam_req_i,
  input  logic                 mam_we_i,
  input  logic [`DBG_PLEN-1:0] mam_addr_i,
  input  logic [3:0]           mam_len_i,
  input  logic [`DBG_XLEN-1:0] mam_wdata_i,
  output logic [`DBG_XLEN-1:0] mam_rdata_o,
  output logic                 mam_rvalid_o,
  output logic                 mam_done_o,
  output logic                 mam_err_o,
  output logic                 mam_busy_o
);

  // MAM master bus
  logic                 mam_hsel;
  logic [`DBG_PLEN-1:0] mam_haddr;
  logic [`DBG_XLEN-1:0] mam_hwdata;
  logic                 mam_hwrite;
  logic [2:0]           mam_hsize;
  logic [2:0]           mam_hburst;
  logic [1:0]           mam_htrans;
  logic                 mam_hmastlock;
  logic [`DBG_XLEN-1:0] mam_hrdata;
  logic                 mam_hready;
  logic                 mam_hresp;

  // Memory bus
  logic                 mem_hsel;
  logic [`DBG_PLEN-1:0] mem_haddr;
  logic [`DBG_XLEN-1:0] mem_hwdata;
  logic                 mem_hwrite;
  logic [1:0]           mem_htrans;
  logic [`DBG_XLEN-1:0] mem_hrdata;
  logic                 mem_hready;
  logic                 mem_hresp;

  dbg_mam_access_engine u_mam (
    .ahb3_in_clk_i        (ahb3_in_clk_i),
    .arst_n_i             (arst_n_i),
    .mam_req_i            (mam_req_i),
    .mam_we_i             (mam_we_i),
    .mam_addr_i           (mam_addr_i),
    .mam_len_i            (mam_len_i),
    .mam_wdata_i          (mam_wdata_i),
    .mam_rdata_o          (mam_rdata_o),
    .mam_rvalid_o         (mam_rvalid_o),
    .mam_done_o           (mam_done_o),
    .mam_err_o            (mam_err_o),
    .mam_busy_o           (mam_busy_o),
    .ahb3_mam_hsel_o      (mam_hsel),
    .ahb3_mam_haddr_o     (mam_haddr),
    .ahb3_mam_hwdata_o    (mam_hwdata),
    .ahb3_mam_hwrite_o    (mam_hwrite),
    .ahb3_mam_hsize_o     (mam_hsize),
    .ahb3_mam_hburst_o    (mam_hburst),
    .ahb3_mam_htrans_o    (mam_htrans),
    .ahb3_mam_hmastlock_o (mam_hmastlock),
    .ahb3_mam_hrdata_i    (mam_hrdata),
    .ahb3_mam_hready_i    (mam_hready),
    .ahb3_mam_hresp_i     (mam_hresp)
  );

  // SRAM ignores size, burst and lock, so those stay open
  dbg_mam_ahb3_arbiter u_arb (
    .ahb3_in_clk_i        (ahb3_in_clk_i),
    .arst_n_i             (arst_n_i),
    .ahb3_in_hsel_i       (ahb3_in_hsel_i),
    .ahb3_in_haddr_i      (ahb3_in_haddr_i),
    .ahb3_in_hwdata_i     (ahb3_in_hwdata_i),
    .ahb3_in_hwrite_i     (ahb3_in_hwrite_i),
    .ahb3_in_hsize_i      (ahb3_in_hsize_i),
    .ahb3_in_hburst_i     (ahb3_in_hburst_i),
    .ahb3_in_htrans_i     (ahb3_in_htrans_i),
    .ahb3_in_hmastlock_i  (ahb3_in_hmastlock_i),
    .ahb3_in_hrdata_o     (ahb3_in_hrdata_o),
    .ahb3_in_hready_o     (ahb3_in_hready_o),
    .ahb3_in_hresp_o      (ahb3_in_hresp_o),
    .ahb3_mam_hsel_i      (mam_hsel),
    .ahb3_mam_haddr_i     (mam_haddr),
    .ahb3_mam_hwdata_i    (mam_hwdata),
    .ahb3_mam_hwrite_i    (mam_hwrite),
    .ahb3_mam_hsize_i     (mam_hsize),
    .ahb3_mam_hburst_i    (mam_hburst),
    .ahb3_mam_htrans_i    (mam_htrans),
    .ahb3_mam_hmastlock_i (mam_hmastlock),
    .ahb3_mam_hrdata_o    (mam_hrdata),
    .ahb3_mam_hready_o    (mam_hready),
    .ahb3_mam_hresp_o     (mam_hresp),
    .ahb3_mem_hsel_o      (mem_hsel),
    .ahb3_mem_haddr_o     (mem_haddr),
    .ahb3_mem_hwdata_o    (mem_hwdata),
    .ahb3_mem_hwrite_o    (mem_hwrite),
    .ahb3_mem_hsize_o     (),
    .ahb3_mem_hburst_o    (),
    .ahb3_mem_htrans_o    (mem_htrans),
    .ahb3_mem_hmastlock_o (),
    .ahb3_mem_hrdata_i    (mem_hrdata),
    .ahb3_mem_hready_i    (mem_hready),
    .ahb3_mem_hresp_i     (mem_hresp)
  );

  dbg_ahb3_sram u_mem (
    .ahb3_in_clk_i     (ahb3_in_clk_i),
    .arst_n_i          (arst_n_i),
    .ahb3_mem_hsel_i   (mem_hsel),
    .ahb3_mem_haddr_i  (mem_haddr),
    .ahb3_mem_hwdata_i (mem_hwdata),
    .ahb3_mem_hwrite_i (mem_hwrite),
    .ahb3_mem_htrans_i (mem_htrans),
    .ahb3_mem_hrdata_o (mem_hrdata),
    .ahb3_mem_hready_o (mem_hready),
    .ahb3_mem_hresp_o  (mem_hresp)
  );

endmodule

// ==== tests/tb_dbg_mam_tasks.svh ====
/*
 * Bus tasks of the testbench
 * - CPU lock, single transfer, unlock
 * - MAM command with read word collection
 * Inputs change on the falling edge, outputs sampled there too
 */

task automatic cpu_lock();
  @(negedge clk);
  cpu_hmastlock = 1'b1;
endtask

task automatic cpu_unlock();
  @(negedge clk);
  cpu_hmastlock = 1'b0;
  cpu_hsel      = 1'b0;
endtask

// One transfer, the lock is already held
task automatic cpu_xfer(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic resp);
  int n;
  @(negedge clk);
  cpu_hsel   = 1'b1;
  cpu_haddr  = addr;
  cpu_hwrite = we;
  cpu_htrans = dbg_mam_pkg::NONSEQ;
  n = 0;
  // hready seen here decides the next rising edge
  while (!cpu_hready) begin
    @(negedge clk);
    n++;
    if (n > TIMEOUT) abort_run("Timeout: CPU address phase was never accepted");
  end
  @(negedge clk);
  cpu_htrans = dbg_mam_pkg::IDLE;
  cpu_hwdata = wdata;
  n = 0;
  while (!cpu_hready) begin
    @(negedge clk);
    n++;
    if (n > TIMEOUT) abort_run("Timeout: CPU data phase never completed");
  end
  rdata = cpu_hrdata;
  resp  = cpu_hresp;
  if (we && !resp) model[word_idx(addr)] = wdata;
endtask

task automatic cpu_single(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic resp);
  cpu_lock();
  cpu_xfer(we, addr, wdata, rdata, resp);
  cpu_unlock();
endtask

// Strobe a command, gather rvalid words until done
task automatic mam_cmd(input logic we, input logic [31:0] addr, input logic [3:0] len,
                       input logic [31:0] wdata, output logic err);
  int n;
  @(negedge clk);
  mam_req   = 1'b1;
  mam_we    = we;
  mam_addr  = addr;
  mam_len   = len;
  mam_wdata = wdata;
  mam_words.delete();
  @(negedge clk);
  mam_req = 1'b0;
  check_value("mam busy after strobe", 1, mam_busy);
  n = 0;
  while (!mam_done) begin
    if (mam_rvalid) mam_words.push_back(mam_rdata);
    @(negedge clk);
    n++;
    if (n > TIMEOUT) abort_run("Timeout: MAM command never signalled done");
  end
  // Last word comes with done
  if (mam_rvalid) mam_words.push_back(mam_rdata);
  err = mam_err;
  if (we && !err) model[word_idx(addr)] = wdata;
endtask

// ==== tests/tb_dbg_mam_soc.sv ====
/*
 * Testbench for the debug memory access subsystem
 * - clock, reset, LFSR random source and SRAM reference model
 * - CPU and MAM traffic, mixed sources, contention, error responses
 */

`timescale 1ns/1ps
`include "dbg_mam_params.svh"

module tb_dbg_mam_soc;

  localparam int TIMEOUT = 500;

  logic                 clk;
  logic                 arst_n;
  // CPU AHB3 master driven by the testbench
  logic                 cpu_hsel;
  logic [`DBG_PLEN-1:0] cpu_haddr;
  logic [`DBG_XLEN-1:0] cpu_hwdata;
  logic                 cpu_hwrite;
  logic [2:0]           cpu_hsize;
  logic [2:0]           cpu_hburst;
  logic [1:0]           cpu_htrans;
  logic                 cpu_hmastlock;
  logic [`DBG_XLEN-1:0] cpu_hrdata;
  logic                 cpu_hready;
  logic                 cpu_hresp;
  // Debug command port
  logic                 mam_req;
  logic                 mam_we;
  logic [`DBG_PLEN-1:0] mam_addr;
  logic [3:0]           mam_len;
  logic [`DBG_XLEN-1:0] mam_wdata;
  logic [`DBG_XLEN-1:0] mam_rdata;
  logic                 mam_rvalid;
  logic                 mam_done;
  logic                 mam_err;
  logic                 mam_busy;

  // Reference model and collected MAM read words
  logic [`DBG_XLEN-1:0] model [`DBG_MEM_WORDS];
  logic [`DBG_XLEN-1:0] mam_words [$];
  logic [31:0]          lfsr;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  dbg_mam_soc_top dut0 (
    .ahb3_in_clk_i       (clk),
    .arst_n_i            (arst_n),
    .ahb3_in_hsel_i      (cpu_hsel),
    .ahb3_in_haddr_i     (cpu_haddr),
    .ahb3_in_hwdata_i    (cpu_hwdata),
    .ahb3_in_hwrite_i    (cpu_hwrite),
    .ahb3_in_hsize_i     (cpu_hsize),
    .ahb3_in_hburst_i    (cpu_hburst),
    .ahb3_in_htrans_i    (cpu_htrans),
    .ahb3_in_hmastlock_i (cpu_hmastlock),
    .ahb3_in_hrdata_o    (cpu_hrdata),
    .ahb3_in_hready_o    (cpu_hready),
    .ahb3_in_hresp_o     (cpu_hresp),
    .mam_req_i           (mam_req),
    .mam_we_i            (mam_we),
    .mam_addr_i          (mam_addr),
    .mam_len_i           (mam_len),
    .mam_wdata_i         (mam_wdata),
    .mam_rdata_o         (mam_rdata),
    .mam_rvalid_o        (mam_rvalid),
    .mam_done_o          (mam_done),
    .mam_err_o           (mam_err),
    .mam_busy_o          (mam_busy)
  );

  //////////////////////////////
  // Random source and helpers
  //////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // Word slot of a byte address, wraps like the SRAM index
  function automatic int word_idx(input logic [31:0] addr);
    return (addr >> 2) % `DBG_MEM_WORDS;
  endfunction

  // Base address with room for len words below the top
  function automatic logic [31:0] rand_base(input int len);
    int idx;
    idx = rand_bits(16) % `DBG_MEM_WORDS;
    if (idx + len > `DBG_MEM_WORDS) begin
      idx = `DBG_MEM_WORDS - len;
    end
    return idx * 4;
  endfunction

  // Preload value, mixes every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ 32'h5bd1e995;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      abort_run("A checked value differs from the reference model");
    end
  endtask

  // Collected MAM words against the model, base plus 4 per word
  task automatic check_mam_read(input string name, input logic [31:0] base, input int len);
    check_value({name, " word count"}, len, mam_words.size());
    for (int i = 0; i < mam_words.size(); i++) begin
      check_value(name, model[word_idx(base + 4 * i)], mam_words[i]);
    end
  endtask

  `include "tb_dbg_mam_tasks.svh"

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    logic [31:0] a;
    logic [31:0] rd;
    logic [31:0] rd2;
    logic        resp;
    logic        resp2;
    logic        err;
    logic [3:0]  len;
    time         t_mam;
    time         t_cpu;

    lfsr          = 32'h1d3160db;
    arst_n        = 1'b0;
    cpu_hsel      = 1'b0;
    cpu_haddr     = '0;
    cpu_hwdata    = '0;
    cpu_hwrite    = 1'b0;
    cpu_hsize     = 3'b010;
    cpu_hburst    = 3'b000;
    cpu_htrans    = dbg_mam_pkg::IDLE;
    cpu_hmastlock = 1'b0;
    mam_req       = 1'b0;
    mam_we        = 1'b0;
    mam_addr      = '0;
    mam_len       = '0;
    mam_wdata     = '0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;

    // Quiet outputs straight after reset
    check_value("reset mam_busy", 0, mam_busy);
    check_value("reset mam_done", 0, mam_done);
    check_value("reset mam_rvalid", 0, mam_rvalid);
    check_value("reset cpu hresp", 0, cpu_hresp);

    // Preload every word through the CPU port
    for (int i = 0; i < `DBG_MEM_WORDS; i++) begin
      cpu_single(1'b1, i * 4, fill_word(i * 4), rd, resp);
      check_value("preload hresp", 0, resp);
    end

    // CPU write and readback
    repeat (20) begin
      a = rand_base(1);
      cpu_single(1'b1, a, rand_bits(32), rd, resp);
      check_value("cpu write hresp", 0, resp);
      cpu_single(1'b0, a, '0, rd, resp);
      check_value("cpu read hresp", 0, resp);
      check_value("cpu readback", model[word_idx(a)], rd);
    end

    // MAM single writes, then reads of 1 to 8 words
    repeat (10) begin
      mam_cmd(1'b1, rand_base(1), 4'd1, rand_bits(32), err);
      check_value("mam write err", 0, err);
      check_value("mam write rvalid count", 0, mam_words.size());
    end
    repeat (10) begin
      len = 4'd1 + 4'(rand_bits(3));
      a   = rand_base(len);
      mam_cmd(1'b0, a, len, '0, err);
      check_value("mam read err", 0, err);
      check_mam_read("mam read", a, len);
    end

    // CPU writes seen by the MAM, MAM writes seen by the CPU
    a = rand_base(4);
    for (int j = 0; j < 4; j++) begin
      cpu_single(1'b1, a + 4 * j, rand_bits(32), rd, resp);
      check_value("mixed cpu write hresp", 0, resp);
    end
    mam_cmd(1'b0, a, 4'd4, '0, err);
    check_value("mixed mam read err", 0, err);
    check_mam_read("cpu data via mam", a, 4);
    a = rand_base(4);
    for (int j = 0; j < 4; j++) begin
      mam_cmd(1'b1, a + 4 * j, 4'd1, rand_bits(32), err);
      check_value("mixed mam write err", 0, err);
    end
    for (int j = 0; j < 4; j++) begin
      cpu_single(1'b0, a + 4 * j, '0, rd, resp);
      check_value("mam data via cpu", model[word_idx(a + 4 * j)], rd);
    end

    // MAM request while the CPU holds its lock over two transfers
    a   = rand_base(5);
    len = 4'd5;
    fork
      begin
        cpu_lock();
        cpu_xfer(1'b1, a, rand_bits(32), rd, resp);
        check_value("locked cpu write hresp", 0, resp);
        cpu_xfer(1'b0, a + 4, '0, rd, resp);
        check_value("locked cpu read hresp", 0, resp);
        check_value("locked cpu read", model[word_idx(a + 4)], rd);
        cpu_unlock();
      end
      begin
        repeat (3) @(negedge clk);
        mam_cmd(1'b0, a, len, '0, err);
      end
    join
    check_value("waiting mam read err", 0, err);
    check_mam_read("waiting mam read", a, len);

    // Both locks first seen in one idle cycle, MAM goes first
    a = rand_base(3);
    fork
      begin
        mam_cmd(1'b0, a, 4'd3, '0, err);
        t_mam = $time;
      end
      begin
        @(negedge clk);
        cpu_lock();
        cpu_xfer(1'b0, a, '0, rd2, resp2);
        t_cpu = $time;
        cpu_unlock();
      end
    join
    check_value("mam done before cpu data", 1, t_mam < t_cpu);
    check_value("same cycle mam read err", 0, err);
    check_mam_read("same cycle mam read", a, 3);
    check_value("same cycle cpu read hresp", 0, resp2);
    check_value("same cycle cpu read", model[word_idx(a)], rd2);

    // Out of range accesses
    a = 32'h400 + rand_base(1);
    cpu_single(1'b1, a, rand_bits(32), rd, resp);
    check_value("cpu bad write hresp", 1, resp);
    cpu_single(1'b0, a, '0, rd, resp);
    check_value("cpu bad read hresp", 1, resp);
    cpu_single(1'b0, word_idx(a) * 4, '0, rd, resp);
    check_value("aliased word unchanged", model[word_idx(a)], rd);
    mam_cmd(1'b0, (`DBG_MEM_WORDS - 1) * 4, 4'd3, '0, err);
    check_value("mam read past end err", 1, err);
    check_mam_read("mam read past end", (`DBG_MEM_WORDS - 1) * 4, 1);
    cpu_single(1'b0, (`DBG_MEM_WORDS - 1) * 4, '0, rd, resp);
    check_value("last word unchanged", model[`DBG_MEM_WORDS - 1], rd);

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
+incdir+tests
src/dbg_mam_pkg.sv
src/dbg_mam_access_engine.sv
src/dbg_mam_ahb3_arbiter.sv
src/dbg_ahb3_sram.sv
src/dbg_mam_soc_top.sv
tests/tb_dbg_mam_soc.sv
